/* compile.f */
src/pe_pkg.sv
src/pe_packet_receiver.sv
src/pe_packet_sender.sv
src/pe_status_register.sv
src/pe_app_handlers.sv
src/pe_node_control.sv
src/pe_node_top.sv
verification/pe_node_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the node testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module pe_node_tb -o pe_node_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pe_node_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
    exit 0
fi
exit 1

/* src/pe_app_handlers.sv */
`timescale 1ns/1ps

module pe_app_handlers import pe_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,

    input  logic     packet_strobe,
    input  payload_t packet_payload,
    input  payload_t sum,
    output payload_t sum_next,

    input  logic     send_fire,
    output logic     rts
);

    logic [16:0] wide_sum;
    logic        pending;

    // Saturating add for the receive handler
    assign wide_sum = {1'b0, sum} + {1'b0, packet_payload};
    assign sum_next = wide_sum[16] ? '1 : wide_sum[15:0];

    // Send handler wants to run after every good receive
    assign rts = pending;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending <= 1'b0;
        end else if (packet_strobe) begin
            pending <= 1'b1;
        end else if (send_fire) begin
            pending <= 1'b0;
        end
    end

endmodule

/* src/pe_node_control.sv */
`timescale 1ns/1ps

module pe_node_control import pe_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  node_addr_t  node_address,

    input  logic        packet_valid,
    input  node_addr_t  pkt_dest,
    input  lamport_t    pkt_lamport,
    output logic        accept_enable,

    input  node_state_t node_state,
    input  payload_t    sum,
    input  lamport_t    lamport,
    input  target_cnt_t target_count,
    input  node_addr_t  target_addr,
    output logic        state_write,
    output node_state_t state_next,
    output logic        sum_write,
    output payload_t    sum_value,
    output logic        lamport_write,
    output lamport_t    lamport_next,
    output target_idx_t target_sel,

    input  logic        rts,
    input  payload_t    sum_next,
    output logic        packet_strobe,
    output logic        send_fire,

    output logic        load_packet,
    output node_addr_t  out_dest,
    output lamport_t    out_lamport,
    output payload_t    out_payload,
    input  logic        sending
);

    ctrl_state_t seq_state;
    logic        rx_error;
    lamport_t    lamport_cur;
    payload_t    sum_cur;
    lamport_t    lamport_max;
    logic        last_target;

    // Forward writes still in flight to the status register
    assign lamport_cur = lamport_write ? lamport_next : lamport;
    assign sum_cur     = sum_write ? sum_value : sum;
    assign lamport_max = (lamport_cur > pkt_lamport) ? lamport_cur : pkt_lamport;

    assign rx_error      = packet_valid &&
                           (pkt_dest != node_address || node_state != NODE_RUNNING);
    assign packet_strobe = packet_valid && !rx_error;
    assign accept_enable = (node_state == NODE_RUNNING || node_state == NODE_STOPPED) &&
                           !rx_error && !state_write;

    assign send_fire   = rts && (seq_state == CTRL_IDLE) && !packet_valid &&
                         (target_count != '0);
    assign last_target = (target_cnt_t'(target_sel) + 4'd1) >= target_count;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            seq_state     <= CTRL_IDLE;
            state_write   <= 1'b0;
            sum_write     <= 1'b0;
            lamport_write <= 1'b0;
            load_packet   <= 1'b0;
            target_sel    <= '0;
        end else begin
            state_write   <= rx_error;
            sum_write     <= packet_strobe;
            lamport_write <= packet_strobe || send_fire;
            load_packet   <= 1'b0;

            case (seq_state)
                CTRL_IDLE: if (send_fire) begin
                    seq_state  <= CTRL_LOAD;
                    target_sel <= '0;
                end
                CTRL_LOAD: if (!sending) begin
                    load_packet <= 1'b1;
                    seq_state   <= CTRL_WAIT;
                end
                CTRL_WAIT: if (!load_packet && !sending) begin
                    seq_state  <= last_target ? CTRL_IDLE : CTRL_LOAD;
                    target_sel <= target_sel + 3'd1;
                end
                default: seq_state <= CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        state_next <= NODE_ERROR;    // Only internal state change
        if (packet_strobe) begin
            sum_value    <= sum_next;
            lamport_next <= lamport_max + 16'd1;
        end else if (send_fire) begin
            lamport_next <= lamport_cur + 16'd1;
            out_lamport  <= lamport_cur + 16'd1; // Same clock for the whole round
            out_payload  <= sum_cur;
        end
        if (seq_state == CTRL_LOAD && !sending)
            out_dest <= target_addr;
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        load_packet |-> target_cnt_t'(target_sel) < target_count);

endmodule

/* src/pe_node_top.sv */
`timescale 1ns/1ps

module pe_node_top import pe_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  node_addr_t node_address,

    input  data_beat_t input_data,
    input  logic       input_startofpacket,
    input  logic       input_endofpacket,
    input  logic       input_valid,
    output logic       input_ready,

    output data_beat_t output_data,
    output logic       output_startofpacket,
    output logic       output_endofpacket,
    output logic       output_valid,
    input  logic       output_ready,

    input  mem_addr_t  mem_address,
    input  logic       mem_write,
    input  mem_data_t  mem_writedata,
    output mem_data_t  mem_readdata
);

    // Receiver to control and handlers
    logic        packet_valid;
    node_addr_t  pkt_dest;
    lamport_t    pkt_lamport;
    payload_t    pkt_payload;
    logic        accept_enable;

    // Status register
    node_state_t node_state;
    node_state_t state_next;
    payload_t    sum;
    payload_t    sum_value;
    lamport_t    lamport;
    lamport_t    lamport_next;
    target_cnt_t target_count;
    node_addr_t  target_addr;
    target_idx_t target_sel;
    logic        state_write;
    logic        sum_write;
    logic        lamport_write;

    // Handlers and sender
    payload_t    sum_next;
    logic        packet_strobe;
    logic        send_fire;
    logic        rts;
    logic        load_packet;
    node_addr_t  out_dest;
    lamport_t    out_lamport;
    payload_t    out_payload;
    logic        sending;

    pe_packet_receiver i_receiver (.pkt_src(), .*); // Source not needed by the application

    pe_packet_sender i_sender (.*);

    pe_status_register i_status (.sum_next(sum_value), .*);

    pe_app_handlers i_handlers (.packet_payload(pkt_payload), .*);

    pe_node_control i_control (.*);

endmodule

/* src/pe_packet_receiver.sv */
`timescale 1ns/1ps

module pe_packet_receiver import pe_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,

    input  data_beat_t input_data,
    input  logic       input_startofpacket,
    input  logic       input_endofpacket,
    input  logic       input_valid,
    output logic       input_ready,

    input  logic       accept_enable,

    output logic       packet_valid,
    output node_addr_t pkt_dest,
    output node_addr_t pkt_src,
    output lamport_t   pkt_lamport,
    output payload_t   pkt_payload
);

    typedef enum logic {RX_HEAD, RX_TAIL} rx_state_t;

    rx_state_t  rx_state;
    data_beat_t head_beat;
    data_beat_t tail_beat;
    logic       beat_fire;
    logic       head_fire;
    logic       tail_fire;

    assign beat_fire = input_valid && input_ready;
    assign head_fire = beat_fire && input_startofpacket; // Any sop restarts the packet
    assign tail_fire = beat_fire && !input_startofpacket && input_endofpacket &&
                       (rx_state == RX_TAIL);

    assign pkt_dest    = head_beat[31:16];
    assign pkt_src     = head_beat[15:0];
    assign pkt_lamport = tail_beat[31:16];
    assign pkt_payload = tail_beat[15:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_state     <= RX_HEAD;
            input_ready  <= 1'b0;
            packet_valid <= 1'b0;
        end else begin
            packet_valid <= 1'b0;
            input_ready  <= accept_enable;
            if (head_fire) begin
                rx_state <= RX_TAIL;
            end else if (tail_fire) begin
                rx_state     <= RX_HEAD;
                packet_valid <= 1'b1;
                input_ready  <= 1'b0;    // One idle cycle while control consumes
            end else if (beat_fire) begin
                rx_state <= RX_HEAD;     // Stray beat, drop it
            end
        end
    end

    always_ff @(posedge clk) begin
        if (head_fire)
            head_beat <= input_data;
        if (tail_fire)
            tail_beat <= input_data;
    end

    // Ready drop after each packet keeps pulses apart
    assert property (@(posedge clk) disable iff (!reset_n)
        packet_valid |=> !packet_valid);

endmodule

/* src/pe_packet_sender.sv */
`timescale 1ns/1ps

module pe_packet_sender import pe_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,

    input  logic       load_packet,
    input  node_addr_t out_dest,
    input  node_addr_t node_address,
    input  lamport_t   out_lamport,
    input  payload_t   out_payload,

    output data_beat_t output_data,
    output logic       output_startofpacket,
    output logic       output_endofpacket,
    output logic       output_valid,
    input  logic       output_ready,

    output logic       sending
);

    data_beat_t tail_beat;
    logic       beat_fire;

    assign beat_fire = output_valid && output_ready;
    assign sending   = output_valid; // Busy until the tail beat goes out

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            output_valid         <= 1'b0;
            output_startofpacket <= 1'b0;
            output_endofpacket   <= 1'b0;
        end else if (load_packet) begin
            output_valid         <= 1'b1;
            output_startofpacket <= 1'b1;
            output_endofpacket   <= 1'b0;
        end else if (beat_fire) begin
            if (output_startofpacket) begin
                output_startofpacket <= 1'b0;
                output_endofpacket   <= 1'b1;
            end else begin
                output_valid       <= 1'b0;
                output_endofpacket <= 1'b0;
            end
        end
    end

    // Beat 0 goes out straight away, beat 1 waits in tail_beat
    always_ff @(posedge clk) begin
        if (load_packet) begin
            output_data <= {out_dest, node_address};
            tail_beat   <= {out_lamport, out_payload};
        end else if (beat_fire && output_startofpacket) begin
            output_data <= tail_beat;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        load_packet |-> !sending);

endmodule

/* src/pe_pkg.sv */
package pe_pkg;

    localparam int MAX_TARGETS = 8;

    // Stream and register widths
    typedef logic [31:0] data_beat_t;
    typedef logic [15:0] node_addr_t;
    typedef logic [15:0] lamport_t;
    typedef logic [15:0] payload_t;    // Also the running sum
    typedef logic [3:0]  mem_addr_t;
    typedef logic [15:0] mem_data_t;
    typedef logic [2:0]  target_idx_t;
    typedef logic [3:0]  target_cnt_t; // 0 to MAX_TARGETS

    // Host register map
    localparam mem_addr_t REG_STATE        = 4'd0;
    localparam mem_addr_t REG_SUM          = 4'd1;
    localparam mem_addr_t REG_LAMPORT      = 4'd2;
    localparam mem_addr_t REG_TARGET_COUNT = 4'd3;
    localparam mem_addr_t REG_TARGET_BASE  = 4'd4; // Target i at 4+i

    // Beat 0 is {dest, src}, beat 1 is {lamport, payload}

    typedef enum logic [1:0] {
        NODE_BOOTED,
        NODE_RUNNING,
        NODE_STOPPED,
        NODE_ERROR
    } node_state_t;

    // Fanout sequencer
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOAD,
        CTRL_WAIT
    } ctrl_state_t;

endpackage

/* src/pe_status_register.sv */
`timescale 1ns/1ps

module pe_status_register import pe_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,

    input  mem_addr_t   mem_address,
    input  logic        mem_write,
    input  mem_data_t   mem_writedata,
    output mem_data_t   mem_readdata,

    input  logic        state_write,
    input  node_state_t state_next,
    input  logic        sum_write,
    input  payload_t    sum_next,
    input  logic        lamport_write,
    input  lamport_t    lamport_next,
    input  target_idx_t target_sel,

    output node_state_t node_state,
    output payload_t    sum,
    output lamport_t    lamport,
    output target_cnt_t target_count,
    output node_addr_t  target_addr
);

    node_addr_t  targets [MAX_TARGETS];
    target_idx_t host_idx;
    logic        host_target;
    target_cnt_t count_clamped;

    assign host_idx    = target_idx_t'(mem_address - REG_TARGET_BASE);
    assign host_target = (mem_address >= REG_TARGET_BASE) &&
                         (mem_address < REG_TARGET_BASE + mem_addr_t'(MAX_TARGETS));
    assign count_clamped = (mem_writedata > mem_data_t'(MAX_TARGETS)) ?
                           target_cnt_t'(MAX_TARGETS) : mem_writedata[3:0];

    assign target_addr = targets[target_sel];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            node_state   <= NODE_BOOTED;
            sum          <= '0;
            lamport      <= '0;
            target_count <= '0;
        end else begin
            if (state_write)
                node_state <= state_next;
            if (sum_write)
                sum <= sum_next;
            if (lamport_write)
                lamport <= lamport_next;
            if (mem_write) begin // Later assignment, host wins
                case (mem_address)
                    REG_STATE:        node_state   <= node_state_t'(mem_writedata[1:0]);
                    REG_SUM:          sum          <= mem_writedata;
                    REG_LAMPORT:      lamport      <= mem_writedata;
                    REG_TARGET_COUNT: target_count <= count_clamped;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write && host_target)
            targets[host_idx] <= mem_writedata;
    end

    always_ff @(posedge clk) begin
        case (mem_address)
            REG_STATE:        mem_readdata <= mem_data_t'(node_state);
            REG_SUM:          mem_readdata <= sum;
            REG_LAMPORT:      mem_readdata <= lamport;
            REG_TARGET_COUNT: mem_readdata <= mem_data_t'(target_count);
            default:          mem_readdata <= host_target ? targets[host_idx] : '0;
        endcase
    end

endmodule

/* verification/pe_node_tb.sv */
`timescale 1ns/1ps

module pe_node_tb import pe_pkg::*; ();

    localparam node_addr_t NODE_ADDR   = 16'h0042;
    localparam int         NUM_ROWS    = 14;
    localparam int         CYCLE_LIMIT = 200 * NUM_ROWS + 100; // Rows plus reset and setup

    typedef enum logic [1:0] {HOST_NONE, HOST_TARGETS, HOST_STATE} host_op_t;

    typedef struct packed {
        host_op_t   op;
        mem_data_t  host_value;    // Target count or node state
        logic       send;
        node_addr_t dest;
        node_addr_t src;
        lamport_t   lamport;
        payload_t   payload;
        logic       random_ready;
    } row_t;

    logic        clk;
    logic        reset_n;
    node_addr_t  node_address;
    data_beat_t  input_data;
    logic        input_startofpacket;
    logic        input_endofpacket;
    logic        input_valid;
    logic        input_ready;
    data_beat_t  output_data;
    logic        output_startofpacket;
    logic        output_endofpacket;
    logic        output_valid;
    logic        output_ready;
    mem_addr_t   mem_address;
    logic        mem_write;
    mem_data_t   mem_writedata;
    mem_data_t   mem_readdata;

    row_t        rows [NUM_ROWS];
    data_beat_t  exp_q [$];
    data_beat_t  got_q [$];
    logic [15:0] lfsr;
    logic        random_ready;
    logic        out_tail;
    int          cycle_count;
    int          beat_errors;
    int          word_errors;
    int          state_errors;
    int          other_errors;

    // Reference model of the node
    node_state_t model_state;
    payload_t    model_sum;
    lamport_t    model_lamport;
    target_cnt_t model_count;
    node_addr_t  model_targets [MAX_TARGETS];
    logic        model_pending;

    pe_node_top i_dut (.*);

    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    always @(negedge clk) begin
        if (random_ready) begin
            lfsr = lfsr_next(lfsr);
            output_ready = lfsr[0];
        end else begin
            output_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (reset_n && output_valid && output_ready) begin
            if (output_startofpacket != !out_tail || output_endofpacket != out_tail) begin
                $display("Output framing wrong at %0t, sop %b eop %b", $time,
                         output_startofpacket, output_endofpacket);
                other_errors++;
            end
            out_tail = !out_tail;
            got_q.push_back(output_data);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_beat(input data_beat_t got, input data_beat_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            beat_errors++;
        end
    endtask

    task automatic check_word(input mem_data_t got, input mem_data_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_state(input node_state_t got, input node_state_t exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
            state_errors++;
        end
    endtask

    task automatic host_write(input mem_addr_t addr, input mem_data_t data);
        @(negedge clk);
        mem_address   = addr;
        mem_writedata = data;
        mem_write     = 1'b1;
        @(negedge clk);
        mem_write     = 1'b0;
    endtask

    task automatic host_read(input mem_addr_t addr, output mem_data_t data);
        @(negedge clk);
        mem_address = addr;
        @(negedge clk);
        data = mem_readdata;    // Registered one cycle after the address
    endtask

    function automatic node_addr_t target_entry(input int row, input int idx);
        return node_addr_t'(16'hA000 + row * 16 + idx);
    endfunction

    // A round goes out whenever a send is pending and the table is not empty
    task automatic model_fanout();
        if (model_pending && model_count != 0) begin
            model_lamport = model_lamport + 16'd1;
            for (int i = 0; i < int'(model_count); i++) begin
                exp_q.push_back({model_targets[i], NODE_ADDR});
                exp_q.push_back({model_lamport, model_sum});
            end
            model_pending = 1'b0;
        end
    endtask

    task automatic model_receive(input row_t row);
        int total;
        if (row.dest != NODE_ADDR || model_state == NODE_STOPPED) begin
            model_state = NODE_ERROR;
        end else begin
            total = int'(model_sum) + int'(row.payload);
            model_sum = (total > 65535) ? 16'hFFFF : payload_t'(total);
            model_lamport = ((model_lamport > row.lamport) ? model_lamport : row.lamport) + 16'd1;
            model_pending = 1'b1;
            model_fanout();
        end
    endtask

    task automatic apply_host(input int r);
        mem_data_t rd;
        case (rows[r].op)
            HOST_TARGETS: begin
                for (int i = 0; i < MAX_TARGETS; i++) begin
                    host_write(REG_TARGET_BASE + mem_addr_t'(i), target_entry(r, i));
                    model_targets[i] = target_entry(r, i);
                end
                host_write(REG_TARGET_COUNT, rows[r].host_value); // Count goes last as it may start a round
                model_count = (rows[r].host_value > mem_data_t'(MAX_TARGETS)) ?
                              target_cnt_t'(MAX_TARGETS) : target_cnt_t'(rows[r].host_value);
                model_fanout();
                host_read(REG_TARGET_COUNT, rd);
                check_word(rd, mem_data_t'(model_count), "target count");
                for (int i = 0; i < MAX_TARGETS; i++) begin
                    host_read(REG_TARGET_BASE + mem_addr_t'(i), rd);
                    check_word(rd, model_targets[i], "target entry");
                end
            end
            HOST_STATE: begin
                host_write(REG_STATE, rows[r].host_value);
                model_state = node_state_t'(rows[r].host_value[1:0]);
            end
            default: ;
        endcase
    endtask

    task automatic offer_packet(input row_t row, input logic expect_accept);
        @(negedge clk);
        input_valid         = 1'b1;
        input_startofpacket = 1'b1;
        input_endofpacket   = 1'b0;
        input_data          = {row.dest, row.src};
        if (!expect_accept) begin
            repeat (20) begin
                @(negedge clk);
                if (input_ready) begin
                    $display("Packet accepted at %0t by a node in state %0d", $time, model_state);
                    other_errors++;
                end
            end
        end else begin
            while (!input_ready) @(negedge clk);
            @(negedge clk);
            input_startofpacket = 1'b0;
            input_endofpacket   = 1'b1;
            input_data          = {row.lamport, row.payload};
            while (!input_ready) @(negedge clk);
            @(negedge clk);
        end
        input_valid         = 1'b0;
        input_startofpacket = 1'b0;
        input_endofpacket   = 1'b0;
    endtask

    initial begin
        mem_data_t rd;
        logic      accept;
        clk = 1'b0;
        reset_n = 1'b0;
        node_address = NODE_ADDR;
        input_data = '0;
        input_startofpacket = 1'b0;
        input_endofpacket = 1'b0;
        input_valid = 1'b0;
        output_ready = 1'b0;
        mem_address = '0;
        mem_write = 1'b0;
        mem_writedata = '0;
        random_ready = 1'b0;
        lfsr = 16'd70;
        out_tail = 1'b0;
        cycle_count = 0;
        beat_errors = 0;
        word_errors = 0;
        state_errors = 0;
        other_errors = 0;
        model_state = NODE_BOOTED;
        model_sum = '0;
        model_lamport = '0;
        model_count = '0;
        model_pending = 1'b0;

        //          op            value  send dest        src      lamport payload rand
        rows[0]  = '{HOST_NONE,    16'd0,  1'b1, NODE_ADDR, 16'h0007, 16'd1,   16'd9,     1'b0};
        rows[1]  = '{HOST_STATE,   16'd1,  1'b1, NODE_ADDR, 16'h0007, 16'd5,   16'd100,   1'b0};
        rows[2]  = '{HOST_TARGETS, 16'd3,  1'b0, NODE_ADDR, 16'h0000, 16'd0,   16'd0,     1'b0};
        rows[3]  = '{HOST_NONE,    16'd0,  1'b1, NODE_ADDR, 16'h0011, 16'd2,   16'd1000,  1'b0};
        rows[4]  = '{HOST_NONE,    16'd0,  1'b1, NODE_ADDR, 16'h0011, 16'd20,  16'd1000,  1'b1};
        rows[5]  = '{HOST_TARGETS, 16'd8,  1'b1, NODE_ADDR, 16'h0023, 16'd3,   16'd60000, 1'b1};
        rows[6]  = '{HOST_TARGETS, 16'd12, 1'b1, NODE_ADDR, 16'h0023, 16'd24,  16'd5000,  1'b1};
        rows[7]  = '{HOST_NONE,    16'd0,  1'b1, 16'h0043,  16'h0031, 16'd40,  16'd77,    1'b0};
        rows[8]  = '{HOST_NONE,    16'd0,  1'b1, NODE_ADDR, 16'h0031, 16'd41,  16'd78,    1'b0};
        rows[9]  = '{HOST_STATE,   16'd1,  1'b1, NODE_ADDR, 16'h0005, 16'd0,   16'd7,     1'b1};
        rows[10] = '{HOST_STATE,   16'd2,  1'b1, NODE_ADDR, 16'h0005, 16'd90,  16'd3,     1'b0};
        rows[11] = '{HOST_TARGETS, 16'd1,  1'b0, NODE_ADDR, 16'h0000, 16'd0,   16'd0,     1'b0};
        rows[12] = '{HOST_STATE,   16'd1,  1'b1, NODE_ADDR, 16'h0009, 16'd100, 16'd0,     1'b1};
        rows[13] = '{HOST_TARGETS, 16'd0,  1'b1, NODE_ADDR, 16'h0009, 16'd50,  16'd1,     1'b0};

        repeat (16) @(negedge clk);
        reset_n = 1'b1;
        if (input_ready || output_valid) begin
            $display("Stream handshake active right after reset");
            other_errors++;
        end
        host_read(REG_STATE, rd);
        check_state(node_state_t'(rd[1:0]), NODE_BOOTED, "state after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            random_ready = rows[r].random_ready;
            apply_host(r);
            if (rows[r].send) begin
                accept = (model_state == NODE_RUNNING || model_state == NODE_STOPPED);
                offer_packet(rows[r], accept);
                if (accept)
                    model_receive(rows[r]);
            end
            while (got_q.size() < exp_q.size()) @(negedge clk);
            repeat (10) @(negedge clk);    // Room for stray beats
            if (got_q.size() != exp_q.size()) begin
                $display("Row %0d sent %0d beats where %0d were expected", r,
                         got_q.size(), exp_q.size());
                other_errors++;
            end
            while (got_q.size() > 0 && exp_q.size() > 0)
                check_beat(got_q.pop_front(), exp_q.pop_front(), "output beat");
            got_q.delete();
            exp_q.delete();

            host_read(REG_SUM, rd);
            check_word(rd, model_sum, "sum");
            host_read(REG_LAMPORT, rd);
            check_word(rd, model_lamport, "lamport");
            host_read(REG_STATE, rd);
            check_state(node_state_t'(rd[1:0]), model_state, "node state");
            if ((model_state == NODE_ERROR || model_state == NODE_BOOTED) && input_ready) begin
                $display("Row %0d left input_ready high in state %0d", r, model_state);
                other_errors++;
            end
        end

        $display("Errors: beat %0d, word %0d, state %0d, other %0d",
                 beat_errors, word_errors, state_errors, other_errors);
        if (beat_errors + word_errors + state_errors + other_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
